/* sb_pkg.sv */
// shared sizes, functional-unit encoding and derived widths for the scoreboard and its testbench
package sb_pkg;

  // --------------------------------------------------------------------------
  // scoreboard sizes
  // --------------------------------------------------------------------------
  // must stay a power of two, the full flag is the counter msb
  localparam int unsigned NR_ENTRIES = 4;
  // one transaction id indexes one entry
  localparam int unsigned TRANS_ID_BITS = $clog2(NR_ENTRIES);
  // occupancy counter, one bit wider than an id
  localparam int unsigned CNT_BITS = TRANS_ID_BITS + 1;

  // --------------------------------------------------------------------------
  // datapath sizes
  // --------------------------------------------------------------------------
  localparam int unsigned XLEN = 32;
  localparam int unsigned REG_ADDR_BITS = 5;
  // general register file
  localparam int unsigned NR_REGS = 2 ** REG_ADDR_BITS;
  localparam int unsigned NR_WB_PORTS = 2;
  localparam int unsigned CAUSE_BITS = 5;
  // forwarding requests, writeback ports first, then entries
  localparam int unsigned NR_REQS = NR_WB_PORTS + NR_ENTRIES;

  // functional unit of an instruction
  // NONE completes without a writeback
  typedef enum logic [2:0] {
    NONE   = 3'd0,
    ALU    = 3'd1,
    BRANCH = 3'd2,
    LOAD   = 3'd3,
    STORE  = 3'd4,
    MULT   = 3'd5,
    CSR    = 3'd6
  } fu_e;

endpackage

/* sb_ctrl.sv */
// scoreboard control: issue and commit pointers, occupancy count and the issue handshake
`timescale 1ns/1ps

module sb_ctrl (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // decoder side
  input  logic                             decoded_valid_i,
  input  logic                             unresolved_branch_i,
  input  logic                             issue_ack_i,
  // commit and flush
  input  logic                             commit_ack_i,
  input  logic                             flush_i,
  // status
  output logic                             issue_valid_o,
  output logic                             sb_full_o,
  output logic                             alloc_o,
  output logic [sb_pkg::TRANS_ID_BITS-1:0] issue_ptr_o,
  output logic [sb_pkg::TRANS_ID_BITS-1:0] commit_ptr_o
);
  import sb_pkg::*;

  logic [TRANS_ID_BITS-1:0] issue_ptr_q;
  logic [TRANS_ID_BITS-1:0] commit_ptr_q;
  logic [CNT_BITS-1:0]      cnt_q;
  logic                     full;

  // counter msb set means all entries are in use
  assign full      = cnt_q[CNT_BITS-1];
  assign sb_full_o = full;

  // offer the instruction only with room and no branch in flight
  assign issue_valid_o = decoded_valid_i & ~unresolved_branch_i & ~full;
  // an entry is taken on the handshake
  assign alloc_o       = decoded_valid_i & issue_ack_i & ~full;

  // --------------------------------------------------------------------------
  // pointers and occupancy
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else if (flush_i) begin
      // flush drops everything in flight
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      // pointers wrap at the ring size
      issue_ptr_q  <= issue_ptr_q + TRANS_ID_BITS'(alloc_o);
      commit_ptr_q <= commit_ptr_q + TRANS_ID_BITS'(commit_ack_i);
      // alloc and commit in one cycle cancel out
      cnt_q        <= cnt_q + CNT_BITS'(alloc_o) - CNT_BITS'(commit_ack_i);
    end
  end

  assign issue_ptr_o  = issue_ptr_q;
  assign commit_ptr_o = commit_ptr_q;

endmodule

/* sb_entry_store.sv */
// scoreboard entry array, written by allocation, writeback, commit and flush, read at commit
`timescale 1ns/1ps

module sb_entry_store (
  input  logic                                                      clk_i,
  input  logic                                                      rst_ni,
  // allocation
  input  logic                                                      alloc_i,
  input  logic [sb_pkg::TRANS_ID_BITS-1:0]                          alloc_ptr_i,
  input  sb_pkg::fu_e                                               decoded_fu_i,
  input  logic [sb_pkg::REG_ADDR_BITS-1:0]                          decoded_rd_i,
  // writeback ports
  input  logic [sb_pkg::NR_WB_PORTS-1:0]                            wb_valid_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::TRANS_ID_BITS-1:0] wb_trans_id_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::XLEN-1:0]          wb_data_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0]                            wb_ex_valid_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::CAUSE_BITS-1:0]    wb_ex_cause_i,
  // commit and flush
  input  logic                                                      commit_ack_i,
  input  logic [sb_pkg::TRANS_ID_BITS-1:0]                          commit_ptr_i,
  input  logic                                                      flush_i,
  // per-entry state
  output logic [sb_pkg::NR_ENTRIES-1:0]                             entry_issued_o,
  output logic [sb_pkg::NR_ENTRIES-1:0]                             entry_valid_o,
  output sb_pkg::fu_e [sb_pkg::NR_ENTRIES-1:0]                      entry_fu_o,
  output logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::REG_ADDR_BITS-1:0]  entry_rd_o,
  output logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::XLEN-1:0]           entry_result_o,
  // head entry
  output logic                                                      commit_valid_o,
  output sb_pkg::fu_e                                               commit_fu_o,
  output logic [sb_pkg::REG_ADDR_BITS-1:0]                          commit_rd_o,
  output logic [sb_pkg::XLEN-1:0]                                   commit_result_o,
  output logic                                                      commit_ex_valid_o,
  output logic [sb_pkg::CAUSE_BITS-1:0]                             commit_ex_cause_o
);
  import sb_pkg::*;

  // control flags
  logic [NR_ENTRIES-1:0]                  issued_q;
  logic [NR_ENTRIES-1:0]                  valid_q;
  logic [NR_ENTRIES-1:0]                  ex_valid_q;
  // payload
  fu_e  [NR_ENTRIES-1:0]                  fu_q;
  logic [NR_ENTRIES-1:0][REG_ADDR_BITS-1:0] rd_q;
  logic [NR_ENTRIES-1:0][XLEN-1:0]        result_q;
  logic [NR_ENTRIES-1:0][CAUSE_BITS-1:0]  cause_q;

  // --------------------------------------------------------------------------
  // control flags, later updates take priority
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issued_q   <= '0;
      valid_q    <= '0;
      ex_valid_q <= '0;
    end else begin
      // new entry starts incomplete and without exception
      if (alloc_i) begin
        issued_q[alloc_ptr_i]   <= 1'b1;
        valid_q[alloc_ptr_i]    <= 1'b0;
        ex_valid_q[alloc_ptr_i] <= 1'b0;
      end
      // no unit to wait for, done one cycle after issue
      for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
        if (issued_q[i] && fu_q[i] == NONE) begin
          valid_q[i] <= 1'b1;
        end
      end
      // results for entries no longer issued are dropped
      for (int unsigned k = 0; k < NR_WB_PORTS; k++) begin
        if (wb_valid_i[k] && issued_q[wb_trans_id_i[k]]) begin
          valid_q[wb_trans_id_i[k]] <= 1'b1;
          if (wb_ex_valid_i[k]) begin
            ex_valid_q[wb_trans_id_i[k]] <= 1'b1;
          end
        end
      end
      // retire the head
      if (commit_ack_i) begin
        issued_q[commit_ptr_i] <= 1'b0;
        valid_q[commit_ptr_i]  <= 1'b0;
      end
      if (flush_i) begin
        issued_q   <= '0;
        valid_q    <= '0;
        ex_valid_q <= '0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // payload
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      fu_q[alloc_ptr_i] <= decoded_fu_i;
      rd_q[alloc_ptr_i] <= decoded_rd_i;
    end
    for (int unsigned k = 0; k < NR_WB_PORTS; k++) begin
      if (wb_valid_i[k] && issued_q[wb_trans_id_i[k]]) begin
        result_q[wb_trans_id_i[k]] <= wb_data_i[k];
        // cause only meaningful with the exception flag
        if (wb_ex_valid_i[k]) begin
          cause_q[wb_trans_id_i[k]] <= wb_ex_cause_i[k];
        end
      end
    end
  end

  assign entry_issued_o = issued_q;
  assign entry_valid_o  = valid_q;
  assign entry_fu_o     = fu_q;
  assign entry_rd_o     = rd_q;
  assign entry_result_o = result_q;

  // head entry seen by the commit stage
  assign commit_valid_o    = valid_q[commit_ptr_i];
  assign commit_fu_o       = fu_q[commit_ptr_i];
  assign commit_rd_o       = rd_q[commit_ptr_i];
  assign commit_result_o   = result_q[commit_ptr_i];
  assign commit_ex_valid_o = ex_valid_q[commit_ptr_i];
  assign commit_ex_cause_o = cause_q[commit_ptr_i];

endmodule

/* sb_clobber.sv */
// per-register clobber report, the unit of the in-flight entry that will write each register
`timescale 1ns/1ps

module sb_clobber (
  input  logic [sb_pkg::NR_ENTRIES-1:0]                            entry_issued_i,
  input  sb_pkg::fu_e [sb_pkg::NR_ENTRIES-1:0]                     entry_fu_i,
  input  logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::REG_ADDR_BITS-1:0] entry_rd_i,
  output sb_pkg::fu_e [sb_pkg::NR_REGS-1:0]                        rd_clobber_o
);
  import sb_pkg::*;

  // entry i is in flight and writes register r
  logic [NR_REGS-1:0][NR_ENTRIES-1:0] hit;

  always_comb begin
    for (int unsigned r = 0; r < NR_REGS; r++) begin
      for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
        hit[r][i] = entry_issued_i[i] && (entry_rd_i[i] == REG_ADDR_BITS'(r));
      end
    end
    // x0 is never written
    hit[0] = '0;
  end

  // --------------------------------------------------------------------------
  // fixed priority, lowest entry index wins
  // --------------------------------------------------------------------------
  always_comb begin
    for (int unsigned r = 0; r < NR_REGS; r++) begin
      rd_clobber_o[r] = NONE;
      // walk downwards so the lowest match is assigned last
      for (int i = NR_ENTRIES - 1; i >= 0; i--) begin
        if (hit[r][i]) begin
          rd_clobber_o[r] = entry_fu_i[i];
        end
      end
    end
  end

endmodule

/* sb_operand_fwd.sv */
// operand forwarding for one source register from writeback ports and completed entries
`timescale 1ns/1ps

module sb_operand_fwd (
  input  logic [sb_pkg::REG_ADDR_BITS-1:0]                          rs_i,
  // writeback ports
  input  logic [sb_pkg::NR_WB_PORTS-1:0]                            wb_valid_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::TRANS_ID_BITS-1:0] wb_trans_id_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::XLEN-1:0]          wb_data_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0]                            wb_ex_valid_i,
  // entry state
  input  logic [sb_pkg::NR_ENTRIES-1:0]                             entry_issued_i,
  input  logic [sb_pkg::NR_ENTRIES-1:0]                             entry_valid_i,
  input  logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::REG_ADDR_BITS-1:0]  entry_rd_i,
  input  logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::XLEN-1:0]           entry_result_i,
  // forwarded operand
  output logic [sb_pkg::XLEN-1:0]                                   rs_o,
  output logic                                                      rs_valid_o
);
  import sb_pkg::*;

  logic [NR_REQS-1:0]           req;
  logic [NR_REQS-1:0][XLEN-1:0] req_data;
  logic                         hit;

  // --------------------------------------------------------------------------
  // requests, ports at the low indices
  // --------------------------------------------------------------------------
  always_comb begin
    // result on the bus this cycle, faulting results are not usable
    for (int unsigned k = 0; k < NR_WB_PORTS; k++) begin
      req[k]      = wb_valid_i[k] & ~wb_ex_valid_i[k] &
                    (entry_rd_i[wb_trans_id_i[k]] == rs_i);
      req_data[k] = wb_data_i[k];
    end
    // result already held in a completed entry
    for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
      req[NR_WB_PORTS+i]      = entry_issued_i[i] & entry_valid_i[i] & (entry_rd_i[i] == rs_i);
      req_data[NR_WB_PORTS+i] = entry_result_i[i];
    end
  end

  // lowest request index wins
  always_comb begin
    hit  = 1'b0;
    rs_o = '0;
    for (int i = NR_REQS - 1; i >= 0; i--) begin
      if (req[i]) begin
        hit  = 1'b1;
        rs_o = req_data[i];
      end
    end
  end

  // x0 reads from the register file
  assign rs_valid_o = hit & (rs_i != '0);

endmodule

/* scoreboard_top.sv */
// scoreboard top level, connects control, entry store, clobber tracker and operand forwarders
`timescale 1ns/1ps

module scoreboard_top (
  input  logic                                                      clk_i,
  input  logic                                                      rst_ni,
  // decoder and issue stage
  input  logic                                                      decoded_valid_i,
  input  sb_pkg::fu_e                                               decoded_fu_i,
  input  logic [sb_pkg::REG_ADDR_BITS-1:0]                          decoded_rd_i,
  input  logic                                                      unresolved_branch_i,
  input  logic                                                      issue_ack_i,
  output logic                                                      issue_valid_o,
  output logic [sb_pkg::TRANS_ID_BITS-1:0]                          issue_trans_id_o,
  output logic                                                      sb_full_o,
  // writeback ports
  input  logic [sb_pkg::NR_WB_PORTS-1:0]                            wb_valid_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::TRANS_ID_BITS-1:0] wb_trans_id_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::XLEN-1:0]          wb_data_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0]                            wb_ex_valid_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::CAUSE_BITS-1:0]    wb_ex_cause_i,
  // commit port
  output logic                                                      commit_valid_o,
  output logic [sb_pkg::TRANS_ID_BITS-1:0]                          commit_trans_id_o,
  output sb_pkg::fu_e                                               commit_fu_o,
  output logic [sb_pkg::REG_ADDR_BITS-1:0]                          commit_rd_o,
  output logic [sb_pkg::XLEN-1:0]                                   commit_result_o,
  output logic                                                      commit_ex_valid_o,
  output logic [sb_pkg::CAUSE_BITS-1:0]                             commit_ex_cause_o,
  input  logic                                                      commit_ack_i,
  input  logic                                                      flush_i,
  // operand read
  input  logic [sb_pkg::REG_ADDR_BITS-1:0]                          rs1_i,
  input  logic [sb_pkg::REG_ADDR_BITS-1:0]                          rs2_i,
  output logic [sb_pkg::XLEN-1:0]                                   rs1_o,
  output logic [sb_pkg::XLEN-1:0]                                   rs2_o,
  output logic                                                      rs1_valid_o,
  output logic                                                      rs2_valid_o,
  output sb_pkg::fu_e [sb_pkg::NR_REGS-1:0]                         rd_clobber_o
);
  import sb_pkg::*;

  logic                                     alloc;
  logic [TRANS_ID_BITS-1:0]                 issue_ptr;
  logic [TRANS_ID_BITS-1:0]                 commit_ptr;
  logic [NR_ENTRIES-1:0]                    entry_issued;
  logic [NR_ENTRIES-1:0]                    entry_valid;
  fu_e  [NR_ENTRIES-1:0]                    entry_fu;
  logic [NR_ENTRIES-1:0][REG_ADDR_BITS-1:0] entry_rd;
  logic [NR_ENTRIES-1:0][XLEN-1:0]          entry_result;

  // id of the next allocation and of the head
  assign issue_trans_id_o  = issue_ptr;
  assign commit_trans_id_o = commit_ptr;

  sb_ctrl i_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .decoded_valid_i     (decoded_valid_i),
    .unresolved_branch_i (unresolved_branch_i),
    .issue_ack_i         (issue_ack_i),
    .commit_ack_i        (commit_ack_i),
    .flush_i             (flush_i),
    .issue_valid_o       (issue_valid_o),
    .sb_full_o           (sb_full_o),
    .alloc_o             (alloc),
    .issue_ptr_o         (issue_ptr),
    .commit_ptr_o        (commit_ptr)
  );

  sb_entry_store i_store (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .alloc_i           (alloc),
    .alloc_ptr_i       (issue_ptr),
    .decoded_fu_i      (decoded_fu_i),
    .decoded_rd_i      (decoded_rd_i),
    .wb_valid_i        (wb_valid_i),
    .wb_trans_id_i     (wb_trans_id_i),
    .wb_data_i         (wb_data_i),
    .wb_ex_valid_i     (wb_ex_valid_i),
    .wb_ex_cause_i     (wb_ex_cause_i),
    .commit_ack_i      (commit_ack_i),
    .commit_ptr_i      (commit_ptr),
    .flush_i           (flush_i),
    .entry_issued_o    (entry_issued),
    .entry_valid_o     (entry_valid),
    .entry_fu_o        (entry_fu),
    .entry_rd_o        (entry_rd),
    .entry_result_o    (entry_result),
    .commit_valid_o    (commit_valid_o),
    .commit_fu_o       (commit_fu_o),
    .commit_rd_o       (commit_rd_o),
    .commit_result_o   (commit_result_o),
    .commit_ex_valid_o (commit_ex_valid_o),
    .commit_ex_cause_o (commit_ex_cause_o)
  );

  sb_clobber i_clobber (
    .entry_issued_i (entry_issued),
    .entry_fu_i     (entry_fu),
    .entry_rd_i     (entry_rd),
    .rd_clobber_o   (rd_clobber_o)
  );

  // --------------------------------------------------------------------------
  // one forwarder per source operand
  // --------------------------------------------------------------------------
  sb_operand_fwd i_fwd_rs1 (
    .rs_i           (rs1_i),
    .wb_valid_i     (wb_valid_i),
    .wb_trans_id_i  (wb_trans_id_i),
    .wb_data_i      (wb_data_i),
    .wb_ex_valid_i  (wb_ex_valid_i),
    .entry_issued_i (entry_issued),
    .entry_valid_i  (entry_valid),
    .entry_rd_i     (entry_rd),
    .entry_result_i (entry_result),
    .rs_o           (rs1_o),
    .rs_valid_o     (rs1_valid_o)
  );

  sb_operand_fwd i_fwd_rs2 (
    .rs_i           (rs2_i),
    .wb_valid_i     (wb_valid_i),
    .wb_trans_id_i  (wb_trans_id_i),
    .wb_data_i      (wb_data_i),
    .wb_ex_valid_i  (wb_ex_valid_i),
    .entry_issued_i (entry_issued),
    .entry_valid_i  (entry_valid),
    .entry_rd_i     (entry_rd),
    .entry_result_i (entry_result),
    .rs_o           (rs2_o),
    .rs_valid_o     (rs2_valid_o)
  );

endmodule

/* tb_scoreboard.sv */
// testbench for scoreboard_top, applies a stimulus table against a model of the entries
`timescale 1ns/1ps

module tb_scoreboard;
  import sb_pkg::*;

  localparam int A_IDLE   = 0;
  localparam int A_ISSUE  = 1;
  localparam int A_WB     = 2;
  localparam int A_COMMIT = 3;
  localparam int A_FLUSH  = 4;
  localparam int COMMIT_TIMEOUT = 20;

  // one stimulus row, -1 in an expected field means not checked
  // rd holds the exception cause on writeback rows
  typedef struct {
    int              act;
    fu_e             fu;
    logic [4:0]      rd;
    logic [1:0]      tid;
    int              port;
    bit              ex;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    bit              unres;
    int              exp_iv;
    int              exp_tid;
    int              exp_full;
    int              exp_cv;
  } row_t;

  logic clk_i;
  logic rst_ni;
  logic decoded_valid_i;
  fu_e  decoded_fu_i;
  logic [REG_ADDR_BITS-1:0] decoded_rd_i;
  logic unresolved_branch_i;
  logic issue_ack_i;
  logic issue_valid_o;
  logic [TRANS_ID_BITS-1:0] issue_trans_id_o;
  logic sb_full_o;
  logic [NR_WB_PORTS-1:0] wb_valid_i;
  logic [NR_WB_PORTS-1:0][TRANS_ID_BITS-1:0] wb_trans_id_i;
  logic [NR_WB_PORTS-1:0][XLEN-1:0] wb_data_i;
  logic [NR_WB_PORTS-1:0] wb_ex_valid_i;
  logic [NR_WB_PORTS-1:0][CAUSE_BITS-1:0] wb_ex_cause_i;
  logic commit_valid_o;
  logic [TRANS_ID_BITS-1:0] commit_trans_id_o;
  fu_e  commit_fu_o;
  logic [REG_ADDR_BITS-1:0] commit_rd_o;
  logic [XLEN-1:0] commit_result_o;
  logic commit_ex_valid_o;
  logic [CAUSE_BITS-1:0] commit_ex_cause_o;
  logic commit_ack_i;
  logic flush_i;
  logic [REG_ADDR_BITS-1:0] rs1_i;
  logic [REG_ADDR_BITS-1:0] rs2_i;
  logic [XLEN-1:0] rs1_o;
  logic [XLEN-1:0] rs2_o;
  logic rs1_valid_o;
  logic rs2_valid_o;
  fu_e  [NR_REGS-1:0] rd_clobber_o;

  // model of the entry ring
  bit   [NR_ENTRIES-1:0] m_issued;
  bit   [NR_ENTRIES-1:0] m_valid;
  bit   [NR_ENTRIES-1:0] m_exv;
  bit   [NR_ENTRIES-1:0] m_hasres;
  fu_e  m_fu [NR_ENTRIES];
  logic [4:0] m_rd [NR_ENTRIES];
  logic [31:0] m_result [NR_ENTRIES];
  logic [4:0] m_cause [NR_ENTRIES];
  int   head;
  int   tail;
  int   cnt;
  row_t rows[$];

  scoreboard_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic add_row(input int act, input fu_e fu, input logic [4:0] rd,
                         input logic [1:0] tid, input int port, input bit ex,
                         input logic [4:0] rs1, input logic [4:0] rs2, input bit unres,
                         input int exp_iv, input int exp_tid, input int exp_full,
                         input int exp_cv);
    row_t r;
    r = '{act, fu, rd, tid, port, ex, rs1, rs2, unres, exp_iv, exp_tid, exp_full, exp_cv};
    rows.push_back(r);
  endtask

  // port hit first, then lowest completed entry, x0 never valid
  task automatic fwd_expect(input logic [4:0] rs, input row_t r, input logic [31:0] wdata,
                            output bit v, output logic [31:0] d);
    v = 1'b0;
    d = '0;
    if (r.act == A_WB && !r.ex && m_rd[r.tid] == rs) begin
      v = 1'b1;
      d = wdata;
    end
    for (int i = 0; i < NR_ENTRIES; i++) begin
      if (!v && m_issued[i] && m_valid[i] && m_rd[i] == rs) begin
        v = 1'b1;
        d = m_result[i];
      end
    end
    if (rs == 0) v = 1'b0;
  endtask

  // ------------------------------------------------------------------------
  // one clock cycle: drive on negedge, check, update model at posedge
  // ------------------------------------------------------------------------
  task automatic run_cycle(input row_t r, output bit acked);
    logic [31:0] wdata;
    logic [31:0] fdata;
    bit          fvalid;
    bit          alloc;
    bit [NR_ENTRIES-1:0] old_issued;
    fu_e         exp_clob;
    acked = 1'b0;
    wdata = $urandom;
    @(negedge clk_i);
    decoded_valid_i     = (r.act == A_ISSUE);
    decoded_fu_i        = r.fu;
    decoded_rd_i        = r.rd;
    unresolved_branch_i = r.unres;
    // the acks only go up while the model expects the DUT to offer something
    issue_ack_i         = (r.act == A_ISSUE) && !r.unres && (cnt != NR_ENTRIES);
    commit_ack_i        = (r.act == A_COMMIT) && m_valid[head];
    acked               = commit_ack_i;
    wb_valid_i          = '0;
    wb_trans_id_i       = '0;
    wb_data_i           = '0;
    wb_ex_valid_i       = '0;
    wb_ex_cause_i       = '0;
    flush_i             = (r.act == A_FLUSH);
    rs1_i               = r.rs1;
    rs2_i               = r.rs2;
    if (r.act == A_WB) begin
      wb_valid_i[r.port]    = 1'b1;
      wb_trans_id_i[r.port] = r.tid;
      wb_data_i[r.port]     = wdata;
      wb_ex_valid_i[r.port] = r.ex;
      wb_ex_cause_i[r.port] = r.rd;
    end
    #1;
    check_val("issue_valid_o", issue_valid_o,
              decoded_valid_i & ~r.unres & (cnt != NR_ENTRIES));
    if (r.exp_iv >= 0) check_val("issue_valid_o", issue_valid_o, r.exp_iv);
    check_val("issue_trans_id_o", issue_trans_id_o, tail);
    if (r.exp_tid >= 0) check_val("issue_trans_id_o", issue_trans_id_o, r.exp_tid);
    check_val("sb_full_o", sb_full_o, cnt == NR_ENTRIES);
    if (r.exp_full >= 0) check_val("sb_full_o", sb_full_o, r.exp_full);
    check_val("commit_valid_o", commit_valid_o, m_valid[head]);
    if (r.exp_cv >= 0) check_val("commit_valid_o", commit_valid_o, r.exp_cv);
    check_val("commit_trans_id_o", commit_trans_id_o, head);
    for (int g = 0; g < NR_REGS; g++) begin
      exp_clob = NONE;
      for (int i = NR_ENTRIES - 1; i >= 0; i--) begin
        if (g != 0 && m_issued[i] && m_rd[i] == g) exp_clob = m_fu[i];
      end
      check_val($sformatf("rd_clobber_o[%0d]", g), rd_clobber_o[g], exp_clob);
    end
    fwd_expect(r.rs1, r, wdata, fvalid, fdata);
    check_val("rs1_valid_o", rs1_valid_o, fvalid);
    if (fvalid) check_val("rs1_o", rs1_o, fdata);
    fwd_expect(r.rs2, r, wdata, fvalid, fdata);
    check_val("rs2_valid_o", rs2_valid_o, fvalid);
    if (fvalid) check_val("rs2_o", rs2_o, fdata);
    if (acked) begin
      check_val("commit_fu_o", commit_fu_o, m_fu[head]);
      check_val("commit_rd_o", commit_rd_o, m_rd[head]);
      check_val("commit_ex_valid_o", commit_ex_valid_o, m_exv[head]);
      if (m_exv[head]) check_val("commit_ex_cause_o", commit_ex_cause_o, m_cause[head]);
      if (m_hasres[head]) check_val("commit_result_o", commit_result_o, m_result[head]);
    end
    alloc = decoded_valid_i && issue_ack_i && cnt != NR_ENTRIES;
    @(posedge clk_i);
    old_issued = m_issued;
    if (alloc) begin
      m_issued[tail] = 1'b1;
      m_valid[tail]  = 1'b0;
      m_exv[tail]    = 1'b0;
      m_hasres[tail] = 1'b0;
      m_fu[tail]     = r.fu;
      m_rd[tail]     = r.rd;
      tail = (tail + 1) % NR_ENTRIES;
      cnt++;
    end
    for (int i = 0; i < NR_ENTRIES; i++) begin
      if (old_issued[i] && m_fu[i] == NONE) m_valid[i] = 1'b1;
    end
    // writeback to an entry not in flight is dropped
    if (r.act == A_WB && old_issued[r.tid]) begin
      m_valid[r.tid]    = 1'b1;
      m_result[r.tid]   = wdata;
      m_hasres[r.tid]   = 1'b1;
      if (r.ex) begin
        m_exv[r.tid]   = 1'b1;
        m_cause[r.tid] = r.rd;
      end
    end
    if (acked) begin
      m_issued[head] = 1'b0;
      m_valid[head]  = 1'b0;
      head = (head + 1) % NR_ENTRIES;
      cnt--;
    end
    if (r.act == A_FLUSH) begin
      m_issued = '0;
      m_valid  = '0;
      m_exv    = '0;
      head = 0;
      tail = 0;
      cnt  = 0;
    end
  endtask

  // ------------------------------------------------------------------------
  // stimulus table and main loop
  // ------------------------------------------------------------------------
  initial begin
    bit acked;
    int waits;
    void'($urandom(32'hbcc5_3146));
    head = 0;
    tail = 0;
    cnt  = 0;
    m_issued = '0;
    m_valid  = '0;
    m_exv    = '0;
    m_hasres = '0;
    for (int i = 0; i < NR_ENTRIES; i++) begin
      m_fu[i] = NONE;
      m_rd[i] = '0;
      m_result[i] = '0;
      m_cause[i] = '0;
    end
    rst_ni = 1'b0;
    decoded_valid_i = 1'b0;
    decoded_fu_i = NONE;
    decoded_rd_i = '0;
    unresolved_branch_i = 1'b0;
    issue_ack_i = 1'b0;
    wb_valid_i = '0;
    wb_trans_id_i = '0;
    wb_data_i = '0;
    wb_ex_valid_i = '0;
    wb_ex_cause_i = '0;
    commit_ack_i = 1'b0;
    flush_i = 1'b0;
    rs1_i = '0;
    rs2_i = '0;

    //      act       fu      rd  tid port ex rs1 rs2 unres iv tid full cv
    add_row(A_IDLE,   NONE,   0,  0,  0,  0,  0,  0,  0,    0, 0,  0,   0);
    add_row(A_ISSUE,  ALU,    5,  0,  0,  0,  0,  0,  0,    1, 0,  0,  -1);
    add_row(A_IDLE,   NONE,   0,  0,  0,  0,  5,  0,  0,    0, 1,  0,   0);
    add_row(A_ISSUE,  LOAD,   7,  0,  0,  0,  0,  0,  0,    1, 1,  0,  -1);
    add_row(A_ISSUE,  NONE,   9,  0,  0,  0,  0,  0,  0,    1, 2,  0,  -1);
    // branch in flight blocks issue
    add_row(A_ISSUE,  MULT,   3,  0,  0,  0,  0,  0,  1,    0, 3,  0,  -1);
    add_row(A_ISSUE,  MULT,   3,  0,  0,  0,  0,  0,  0,    1, 3,  0,  -1);
    add_row(A_ISSUE,  ALU,    4,  0,  0,  0,  0,  0,  0,    0, 0,  1,  -1);
    // younger NONE entry done, head still waiting
    add_row(A_IDLE,   NONE,   0,  0,  0,  0,  0,  0,  0,    0, -1, 1,   0);
    add_row(A_WB,     NONE,   0,  1,  1,  0,  7,  0,  0,   -1, -1, 1,   0);
    add_row(A_IDLE,   NONE,   0,  0,  0,  0,  7,  7,  0,   -1, -1, 1,   0);
    add_row(A_WB,     NONE,   3,  0,  0,  1,  5,  0,  0,   -1, -1, 1,   0);
    add_row(A_COMMIT, NONE,   0,  0,  0,  0,  0,  0,  0,   -1, -1, -1, -1);
    add_row(A_ISSUE,  ALU,    0,  0,  0,  0,  0,  0,  0,    1, 0,  0,  -1);
    add_row(A_IDLE,   NONE,   0,  0,  0,  0,  5,  0,  0,   -1, -1, 1,  -1);
    // x0 result on the bus and later in an entry, never forwarded
    add_row(A_WB,     NONE,   0,  0,  1,  0,  0,  0,  0,   -1, -1, 1,  -1);
    add_row(A_COMMIT, NONE,   0,  0,  0,  0,  0,  0,  0,   -1, -1, -1, -1);
    add_row(A_COMMIT, NONE,   0,  0,  0,  0,  0,  0,  0,   -1, -1, -1, -1);
    add_row(A_WB,     NONE,   0,  3,  0,  0,  3,  3,  0,   -1, -1, -1, -1);
    add_row(A_COMMIT, NONE,   0,  0,  0,  0,  0,  0,  0,   -1, -1, -1, -1);
    add_row(A_ISSUE,  LOAD,   12, 0,  0,  0,  0,  0,  0,    1, 1,  0,  -1);
    add_row(A_FLUSH,  NONE,   0,  0,  0,  0,  0,  0,  0,   -1, -1, -1, -1);
    add_row(A_IDLE,   NONE,   0,  0,  0,  0,  0,  0,  0,   -1, 0,  0,   0);
    add_row(A_WB,     NONE,   0,  1,  1,  0,  0,  0,  0,   -1, 0,  0,   0);
    add_row(A_IDLE,   NONE,   0,  0,  0,  0,  12, 0,  0,   -1, 0,  0,   0);
    add_row(A_ISSUE,  ALU,    6,  0,  0,  0,  0,  0,  0,    1, 0,  0,   0);
    add_row(A_WB,     NONE,   0,  0,  0,  0,  6,  0,  0,   -1, -1, 0,   0);
    add_row(A_COMMIT, NONE,   0,  0,  0,  0,  6,  0,  0,   -1, -1, -1, -1);

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    foreach (rows[n]) begin
      if (rows[n].act == A_COMMIT) begin
        // idle until the head completes, bounded
        waits = 0;
        acked = 1'b0;
        while (!acked) begin
          if (waits == COMMIT_TIMEOUT) begin
            $display("Timeout: commit_valid_o never rose for row %0d", n);
            $display("Simulation failed");
            $fatal(1);
          end
          run_cycle(rows[n], acked);
          waits++;
        end
      end else begin
        run_cycle(rows[n], acked);
      end
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

/* scoreboard_top.f */
sb_pkg.sv
sb_ctrl.sv
sb_entry_store.sv
sb_clobber.sv
sb_operand_fwd.sv
scoreboard_top.sv
tb_scoreboard.sv

/* run.sh */
#!/bin/sh
# build and run the scoreboard testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --top-module tb_scoreboard -f scoreboard_top.f -o sim_scoreboard \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_scoreboard > sim.log 2>&1
grep -q "Simulation passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
